//--- Makefile
# Verilator simulation of the FIX session message builder

VERILATOR ?= verilator
TOP       ?= fix_msg_builder_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/fix_msg_model.svh
`ifndef FIX_MSG_MODEL_SVH
`define FIX_MSG_MODEL_SVH

// expected text of one session message
// header 8 and 9, body in tag order, then the checksum field
task automatic build_expected_msg(
	input  fix_pkg::msg_type_e t,
	input  string              seq,
	input  string              sender,
	input  string              target,
	input  string              stime,
	input  string              hb,
	output string              msg
);
	string soh;
	string body;
	string head;
	string type_str;
	int sum;
	int i;
	soh = $sformatf("%c", 8'h01);
	case (t)
		fix_pkg::MSG_LOGON:     type_str = "A";
		fix_pkg::MSG_HEARTBEAT: type_str = "0";
		default:                type_str = "5";
	endcase
	body = {"34=", seq, soh, "35=", type_str, soh, "49=", sender, soh,
		"52=", stime, soh, "56=", target, soh};
	// only logon carries encryption and heartbeat interval
	if (t == fix_pkg::MSG_LOGON)
		body = {body, "98=0", soh, "108=", hb, soh};
	head = {"8=FIX.4.4", soh, "9=", $sformatf("%0d", body.len()), soh};
	msg = {head, body};
	sum = 0;
	for (i = 0; i < msg.len(); i++)
		sum += int'(msg[i]);
	msg = {msg, "10=", $sformatf("%03d", sum % 256), soh};
endtask

`endif

//--- bench/fix_msg_builder_tb.sv
`timescale 1ns/1ps

module fix_msg_builder_tb;
	import fix_pkg::*;

	localparam int VALUE_BYTES = 24;
	localparam int VW = VALUE_BYTES * 8;
	localparam int LEN_W = $clog2(VALUE_BYTES + 1);
	localparam int ROWS = 5;
	localparam int SEED = 28889;
	localparam int MID_START_AFTER = 20;
	localparam int QUIET_CYCLES = 40;

	`include "fix_msg_model.svh"

	// stimulus table, one column per array
	msg_type_e type_tab [ROWS] = '{MSG_LOGON, MSG_HEARTBEAT, MSG_LOGON, MSG_LOGOUT, MSG_LOGOUT};
	string seq_tab [ROWS] = '{"1", "2", "123456", "99", "1000000"};
	string sender_tab [ROWS] = '{"CLIENT01", "CLIENT01", "BUYSIDE_GATEWAY_NODE_001",
		"BUYSIDE_GATEWAY_NODE_001", "BUYSIDE_GATEWAY_NODE_001"};
	string target_tab [ROWS] = '{"BROKER", "BROKER", "SELLSIDE_EXCHANGE_VENUE1",
		"SELLSIDE_EXCHANGE_VENUE1", "SELLSIDE_EXCHANGE_VENUE1"};
	string time_tab [ROWS] = '{"20240315-09:30:00.000", "20240315-09:30:30.000",
		"20240315-09:31:00.000", "20240315-09:45:00.000", "20240315-09:45:00.123456"};
	string hb_tab [ROWS] = '{"30", "30", "120", "30", "30"};
	// expected tag 9 value, and whether a second start is pulsed mid-message
	int body_len_tab [ROWS] = '{69, 57, 109, 92, 100};
	bit mid_start_tab [ROWS] = '{0, 1, 0, 0, 1};

	logic clk;
	logic rst;
	logic start_i;
	msg_type_e msg_type_i;
	logic [VW-1:0] seq_num_i, sender_i, target_i, send_time_i, hb_int_i;
	logic [LEN_W-1:0] seq_num_len_i, sender_len_i, target_len_i, send_time_len_i, hb_int_len_i;
	logic [7:0] byte_o;
	logic byte_valid_o;
	logic busy_o;
	logic msg_done_o;

	logic [7:0] cap_q [$];
	int done_cnt;
	int err_cnt;
	int chk_cnt;
	bit in_msg;
	bit prev_valid;
	logic [7:0] prev_byte;

	fix_msg_builder #(.VALUE_BYTES(VALUE_BYTES)) i_dut (
		.clk(clk), .rst(rst), .start_i(start_i), .msg_type_i(msg_type_i),
		.seq_num_i(seq_num_i), .seq_num_len_i(seq_num_len_i),
		.sender_i(sender_i), .sender_len_i(sender_len_i),
		.target_i(target_i), .target_len_i(target_len_i),
		.send_time_i(send_time_i), .send_time_len_i(send_time_len_i),
		.hb_int_i(hb_int_i), .hb_int_len_i(hb_int_len_i),
		.byte_o(byte_o), .byte_valid_o(byte_valid_o),
		.busy_o(busy_o), .msg_done_o(msg_done_o)
	);

	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		chk_cnt++;
		if (actual !== expected) begin
			err_cnt++;
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
				$time);
		end
	endtask

	task automatic report_error(input string what);
		err_cnt++;
		$display("ERROR: %s at %0t", what, $time);
	endtask

	// character k of the string goes to byte k
	function automatic logic [VW-1:0] to_word(input string s);
		logic [VW-1:0] w;
		int k;
		w = '0;
		for (k = 0; k < s.len(); k++)
			w[k*8 +: 8] = s[k];
		return w;
	endfunction

	// byte capture and inter-message checks
	always @(posedge clk) begin
		if (!rst) begin
			if (busy_o)
				in_msg = 1'b1;
			if (byte_valid_o) begin
				if (!in_msg)
					report_error("byte_valid_o high outside a message");
				cap_q.push_back(byte_o);
			end
			if (msg_done_o) begin
				check_value("byte_valid_o before msg_done_o", 32'(prev_valid), 1);
				check_value("byte_o before msg_done_o", 32'(prev_byte), 32'(SOH));
				check_value("byte_valid_o with msg_done_o", 32'(byte_valid_o), 0);
				in_msg = 1'b0;
				done_cnt++;
			end
			prev_valid = byte_valid_o;
			prev_byte = byte_o;
		end
	end

	task automatic apply_row(input int r);
		int gap;
		gap = $urandom_range(7, 0);
		while (busy_o)
			@(posedge clk);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		cap_q.delete();
		start_i <= 1'b1;
		msg_type_i <= type_tab[r];
		seq_num_i <= to_word(seq_tab[r]);
		seq_num_len_i <= LEN_W'(seq_tab[r].len());
		sender_i <= to_word(sender_tab[r]);
		sender_len_i <= LEN_W'(sender_tab[r].len());
		target_i <= to_word(target_tab[r]);
		target_len_i <= LEN_W'(target_tab[r].len());
		send_time_i <= to_word(time_tab[r]);
		send_time_len_i <= LEN_W'(time_tab[r].len());
		hb_int_i <= to_word(hb_tab[r]);
		hb_int_len_i <= LEN_W'(hb_tab[r].len());
		@(posedge clk);
		start_i <= 1'b0;
		// second start while the message is still going out
		if (mid_start_tab[r]) begin
			while (cap_q.size() < MID_START_AFTER)
				@(posedge clk);
			start_i <= 1'b1;
			msg_type_i <= MSG_LOGON;
			@(posedge clk);
			start_i <= 1'b0;
		end
	endtask

	task automatic check_message(input int r);
		string exp_msg;
		int n;
		int i;
		int soh1;
		int soh2;
		int len_val;
		int sum;
		int cks;
		build_expected_msg(type_tab[r], seq_tab[r], sender_tab[r], target_tab[r],
			time_tab[r], hb_tab[r], exp_msg);
		n = cap_q.size();
		check_value("byte_o count", n, exp_msg.len());
		for (i = 0; i < n && i < exp_msg.len(); i++)
			check_value($sformatf("byte_o[%0d]", i), 32'(cap_q[i]), 32'(exp_msg[i]));
		if (n < 20) begin
			report_error($sformatf("row %0d: message too short to parse", r));
			return;
		end
		// the first two SOH bytes close tags 8 and 9
		soh1 = 0;
		while (soh1 < n && cap_q[soh1] != SOH)
			soh1++;
		soh2 = soh1 + 1;
		while (soh2 < n && cap_q[soh2] != SOH)
			soh2++;
		if (soh2 + 1 > n - 7) begin
			report_error($sformatf("row %0d: no body length field found", r));
			return;
		end
		len_val = 0;
		for (i = soh1 + 3; i < soh2; i++)
			len_val = len_val * 10 + int'(cap_q[i]) - 48;
		check_value("byte_o (tag 9 leading zero)", 32'(cap_q[soh1 + 3] == 8'h30), 0);
		check_value("byte_o (tag 9 vs counted)", len_val, n - 7 - (soh2 + 1));
		check_value("byte_o (tag 9 vs table)", len_val, body_len_tab[r]);
		// checksum covers every byte before "10="
		sum = 0;
		for (i = 0; i < n - 7; i++)
			sum += int'(cap_q[i]);
		cks = (int'(cap_q[n-4]) - 48) * 100 + (int'(cap_q[n-3]) - 48) * 10
			+ int'(cap_q[n-2]) - 48;
		check_value("byte_o (tag 10 value)", cks, sum % 256);
	endtask

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst = 1'b1;
		start_i = 1'b0;
		msg_type_i = MSG_HEARTBEAT;
		seq_num_i = '0;
		sender_i = '0;
		target_i = '0;
		send_time_i = '0;
		hb_int_i = '0;
		seq_num_len_i = '0;
		sender_len_i = '0;
		target_len_i = '0;
		send_time_len_i = '0;
		hb_int_len_i = '0;
		done_cnt = 0;
		err_cnt = 0;
		chk_cnt = 0;
		in_msg = 1'b0;
		prev_valid = 1'b0;
		prev_byte = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_value("byte_valid_o after reset", 32'(byte_valid_o), 0);
		check_value("busy_o after reset", 32'(busy_o), 0);
		check_value("msg_done_o after reset", 32'(msg_done_o), 0);
		for (int r = 0; r < ROWS; r++) begin
			apply_row(r);
			wait (done_cnt == r + 1);
			check_message(r);
			if (mid_start_tab[r]) begin
				repeat (QUIET_CYCLES) @(posedge clk);
				check_value("msg_done_o count after second start", done_cnt, r + 1);
				check_value("busy_o after second start", 32'(busy_o), 0);
			end
		end
		check_value("msg_done_o count", done_cnt, ROWS);
		$display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// budget of 200 cycles per table row
	initial begin
		#(ROWS * 200 * 20);
		$display("timeout: the messages did not complete within %0d cycles", ROWS * 200);
		$display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- logic/fix_body_length.sv
`timescale 1ns/1ps

module fix_body_length #(
	parameter int VALUE_BYTES = 16,
	localparam int LEN_W = $clog2(VALUE_BYTES + 1)
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start_i,
	input  fix_pkg::msg_type_e msg_type_i,
	input  logic [LEN_W-1:0]   seq_num_len_i,
	input  logic [LEN_W-1:0]   sender_len_i,
	input  logic [LEN_W-1:0]   target_len_i,
	input  logic [LEN_W-1:0]   send_time_len_i,
	input  logic [LEN_W-1:0]   hb_int_len_i,
	output logic               len_valid_o,
	output logic [23:0]        len_digits_o,
	output logic [1:0]         len_count_o
);
	import fix_pkg::*;

	localparam int SUM_W = 16;

	localparam logic [1:0] B_IDLE = 2'd0;
	localparam logic [1:0] B_HUND = 2'd1;
	localparam logic [1:0] B_TENS = 2'd2;
	localparam logic [1:0] B_DONE = 2'd3;

	logic [1:0] state;
	logic [SUM_W-1:0] sum_next, rem;
	logic [3:0] hund, tens;

	// each field costs its tag, '=', its value and SOH
	always_comb begin
		sum_next = SUM_W'(TAG_SEQ_NUM_LEN) + SUM_W'(seq_num_len_i) + SUM_W'(2)
			+ SUM_W'(TAG_MSG_TYPE_LEN) + SUM_W'(1) + SUM_W'(2)
			+ SUM_W'(TAG_SENDER_LEN) + SUM_W'(sender_len_i) + SUM_W'(2)
			+ SUM_W'(TAG_SEND_TIME_LEN) + SUM_W'(send_time_len_i) + SUM_W'(2)
			+ SUM_W'(TAG_TARGET_LEN) + SUM_W'(target_len_i) + SUM_W'(2);
		if (msg_type_i == MSG_LOGON) begin
			sum_next = sum_next
				+ SUM_W'(TAG_ENCRYPT_LEN) + SUM_W'(ENCRYPT_NONE_LEN) + SUM_W'(2)
				+ SUM_W'(TAG_HB_INT_LEN) + SUM_W'(hb_int_len_i) + SUM_W'(2);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= B_IDLE;
		end else if (start_i) begin
			state <= B_HUND;
		end else begin
			case (state)
				B_HUND: if (rem < SUM_W'(100)) state <= B_TENS;
				B_TENS: if (rem < SUM_W'(10)) state <= B_DONE;
				default: ;
			endcase
		end
	end

	// hundreds, then tens, by repeated subtraction
	always_ff @(posedge clk) begin
		if (start_i) begin
			rem <= sum_next;
			hund <= '0;
			tens <= '0;
		end else if (state == B_HUND && rem >= SUM_W'(100)) begin
			rem <= rem - SUM_W'(100);
			hund <= hund + 4'd1;
		end else if (state == B_TENS && rem >= SUM_W'(10)) begin
			rem <= rem - SUM_W'(10);
			tens <= tens + 4'd1;
		end
	end

	assign len_valid_o = (state == B_DONE);
	assign len_count_o = (hund != '0) ? 2'd3 : 2'd2;

	// most significant digit goes first, in byte 0
	always_comb begin
		if (hund != '0)
			len_digits_o = {4'h3, rem[3:0], 4'h3, tens, 4'h3, hund};
		else
			len_digits_o = {8'h00, 4'h3, rem[3:0], 4'h3, tens};
	end

	assert property (@(posedge clk) disable iff (rst)
		start_i |-> sum_next < SUM_W'(1000));

endmodule

//--- logic/fix_checksum_trailer.sv
`timescale 1ns/1ps

module fix_checksum_trailer (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] byte_i,
	input  logic       byte_valid_i,
	input  logic       trailer_start_i,
	output logic [7:0] byte_o,
	output logic       byte_valid_o,
	output logic       msg_done_o
);
	import fix_pkg::*;

	logic [7:0] sum;
	logic [7:0] d_hund, d_tens, d_ones;
	logic [55:0] tr_r;
	logic [2:0] tr_cnt;
	logic last_r;

	// three digits, leading zeros kept
	always_comb begin
		d_hund = 8'h30 + sum / 8'd100;
		d_tens = 8'h30 + (sum / 8'd10) % 8'd10;
		d_ones = 8'h30 + sum % 8'd10;
	end

	// mod 256 by wrap, cleared once the trailer is formed
	always_ff @(posedge clk) begin
		if (rst || trailer_start_i)
			sum <= '0;
		else if (byte_valid_i)
			sum <= sum + byte_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tr_cnt <= '0;
			last_r <= 1'b0;
			msg_done_o <= 1'b0;
			byte_valid_o <= 1'b0;
		end else begin
			if (trailer_start_i)
				tr_cnt <= 3'(TAG_CHECKSUM_LEN) + 3'd5;
			else if (tr_cnt != '0)
				tr_cnt <= tr_cnt - 3'd1;
			last_r <= (tr_cnt == 3'd1);
			msg_done_o <= last_r;
			byte_valid_o <= byte_valid_i || (tr_cnt != '0);
		end
	end

	// "10=ddd" plus SOH, shifted out low byte first
	always_ff @(posedge clk) begin
		if (trailer_start_i)
			tr_r <= {SOH, d_ones, d_tens, d_hund, EQ, TAG_CHECKSUM[15:0]};
		else if (tr_cnt != '0)
			tr_r <= tr_r >> 8;
		if (tr_cnt != '0)
			byte_o <= tr_r[7:0];
		else
			byte_o <= byte_i;
	end

endmodule

//--- logic/fix_field_sequencer.sv
`timescale 1ns/1ps

module fix_field_sequencer #(
	parameter int VALUE_BYTES = 16,
	localparam int VW = VALUE_BYTES * 8,
	localparam int LEN_W = $clog2(VALUE_BYTES + 1)
) (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic                                         start_i,
	input  fix_pkg::msg_type_e                           msg_type_i,
	input  logic [VW-1:0]                                seq_num_i,
	input  logic [LEN_W-1:0]                             seq_num_len_i,
	input  logic [VW-1:0]                                sender_i,
	input  logic [LEN_W-1:0]                             sender_len_i,
	input  logic [VW-1:0]                                target_i,
	input  logic [LEN_W-1:0]                             target_len_i,
	input  logic [VW-1:0]                                send_time_i,
	input  logic [LEN_W-1:0]                             send_time_len_i,
	input  logic [VW-1:0]                                hb_int_i,
	input  logic [LEN_W-1:0]                             hb_int_len_i,
	input  logic                                         len_valid_i,
	input  logic [23:0]                                  len_digits_i,
	input  logic [1:0]                                   len_count_i,
	input  logic                                         field_done_i,
	input  logic                                         trailer_done_i,
	output logic                                         len_start_o,
	output logic                                         field_load_o,
	output logic [fix_pkg::TAG_BYTES*8-1:0]              field_tag_o,
	output logic [$clog2(fix_pkg::TAG_BYTES+1)-1:0]      field_tag_len_o,
	output logic [VW-1:0]                                field_val_o,
	output logic [LEN_W-1:0]                             field_val_len_o,
	output logic                                         trailer_start_o,
	output logic                                         busy_o
);
	import fix_pkg::*;

	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_LOAD  = 3'd1;
	localparam logic [2:0] S_WAIT  = 3'd2;
	localparam logic [2:0] S_TRAIL = 3'd3;
	localparam logic [2:0] S_END   = 3'd4;

	// field index in message order
	localparam logic [3:0] F_BEGIN    = 4'd0;
	localparam logic [3:0] F_BODY_LEN = 4'd1;
	localparam logic [3:0] F_SEQ      = 4'd2;
	localparam logic [3:0] F_TYPE     = 4'd3;
	localparam logic [3:0] F_SENDER   = 4'd4;
	localparam logic [3:0] F_TIME     = 4'd5;
	localparam logic [3:0] F_TARGET   = 4'd6;
	localparam logic [3:0] F_ENCRYPT  = 4'd7;
	localparam logic [3:0] F_HB_INT   = 4'd8;

	logic [2:0] state;
	logic [3:0] fidx;
	logic last_field;
	msg_type_e type_r;
	logic [VW-1:0] seq_r, sender_r, target_r, time_r, hb_r;
	logic [LEN_W-1:0] seq_len_r, sender_len_r, target_len_r, time_len_r, hb_len_r;

	// heartbeat and logout stop after target
	assign last_field = (fidx == F_HB_INT) || (fidx == F_TARGET && type_r != MSG_LOGON);

	assign len_start_o = (state == S_IDLE) && start_i;
	assign field_load_o = (state == S_LOAD) && (fidx != F_BODY_LEN || len_valid_i);
	assign trailer_start_o = (state == S_TRAIL);
	assign busy_o = (state != S_IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			fidx <= F_BEGIN;
		end else begin
			case (state)
				S_IDLE: begin
					if (start_i) begin
						state <= S_LOAD;
						fidx <= F_BEGIN;
					end
				end
				S_LOAD: begin
					if (field_load_o)
						state <= S_WAIT;
				end
				S_WAIT: begin
					if (field_done_i) begin
						if (last_field) begin
							state <= S_TRAIL;
						end else begin
							fidx <= fidx + 4'd1;
							state <= S_LOAD;
						end
					end
				end
				S_TRAIL: state <= S_END;
				S_END: begin
					if (trailer_done_i)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// message inputs held for the whole message
	always_ff @(posedge clk) begin
		if (len_start_o) begin
			type_r <= msg_type_i;
			seq_r <= seq_num_i;
			seq_len_r <= seq_num_len_i;
			sender_r <= sender_i;
			sender_len_r <= sender_len_i;
			target_r <= target_i;
			target_len_r <= target_len_i;
			time_r <= send_time_i;
			time_len_r <= send_time_len_i;
			hb_r <= hb_int_i;
			hb_len_r <= hb_int_len_i;
		end
	end

	always_comb begin
		field_tag_o = TAG_BEGIN_STRING;
		field_tag_len_o = TAG_BEGIN_STRING_LEN;
		field_val_o = VW'(BEGIN_STRING);
		field_val_len_o = LEN_W'(BEGIN_STRING_LEN);
		case (fidx)
			F_BODY_LEN: begin
				field_tag_o = TAG_BODY_LENGTH;
				field_tag_len_o = TAG_BODY_LENGTH_LEN;
				field_val_o = VW'(len_digits_i);
				field_val_len_o = LEN_W'(len_count_i);
			end
			F_SEQ: begin
				field_tag_o = TAG_SEQ_NUM;
				field_tag_len_o = TAG_SEQ_NUM_LEN;
				field_val_o = seq_r;
				field_val_len_o = seq_len_r;
			end
			F_TYPE: begin
				field_tag_o = TAG_MSG_TYPE;
				field_tag_len_o = TAG_MSG_TYPE_LEN;
				field_val_o = VW'(msg_type_char(type_r));
				field_val_len_o = LEN_W'(1);
			end
			F_SENDER: begin
				field_tag_o = TAG_SENDER;
				field_tag_len_o = TAG_SENDER_LEN;
				field_val_o = sender_r;
				field_val_len_o = sender_len_r;
			end
			F_TIME: begin
				field_tag_o = TAG_SEND_TIME;
				field_tag_len_o = TAG_SEND_TIME_LEN;
				field_val_o = time_r;
				field_val_len_o = time_len_r;
			end
			F_TARGET: begin
				field_tag_o = TAG_TARGET;
				field_tag_len_o = TAG_TARGET_LEN;
				field_val_o = target_r;
				field_val_len_o = target_len_r;
			end
			F_ENCRYPT: begin
				field_tag_o = TAG_ENCRYPT;
				field_tag_len_o = TAG_ENCRYPT_LEN;
				field_val_o = VW'(ENCRYPT_NONE);
				field_val_len_o = LEN_W'(ENCRYPT_NONE_LEN);
			end
			F_HB_INT: begin
				field_tag_o = TAG_HB_INT;
				field_tag_len_o = TAG_HB_INT_LEN;
				field_val_o = hb_r;
				field_val_len_o = hb_len_r;
			end
			default: ;
		endcase
	end

	// a field is in flight from its load until the serializer reports it done
	assert property (@(posedge clk) disable iff (rst)
		field_done_i |-> state == S_WAIT);

	// a start during a message does not restart the length stage
	assert property (@(posedge clk) disable iff (rst)
		start_i && busy_o && len_valid_i |=> len_valid_i);

endmodule

//--- logic/fix_field_serializer.sv
`timescale 1ns/1ps

module fix_field_serializer #(
	parameter int VALUE_BYTES = 16,
	localparam int VW = VALUE_BYTES * 8,
	localparam int LEN_W = $clog2(VALUE_BYTES + 1),
	localparam int TAG_W = fix_pkg::TAG_BYTES * 8,
	localparam int TLEN_W = $clog2(fix_pkg::TAG_BYTES + 1),
	localparam int POS_W = $clog2(fix_pkg::TAG_BYTES + VALUE_BYTES + 2)
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              load_i,
	input  logic [TAG_W-1:0]  tag_i,
	input  logic [TLEN_W-1:0] tag_len_i,
	input  logic [VW-1:0]     val_i,
	input  logic [LEN_W-1:0]  val_len_i,
	output logic [7:0]        byte_o,
	output logic              byte_valid_o,
	output logic              done_o
);
	import fix_pkg::*;

	logic busy;
	logic [POS_W-1:0] pos, eq_pos, last_pos, val_pos;
	logic [TAG_W-1:0] tag_r;
	logic [TLEN_W-1:0] tag_len_r;
	logic [VW-1:0] val_r;
	logic [LEN_W-1:0] val_len_r;

	// layout: tag, '=' at T, value, SOH at T+V+1
	assign eq_pos = POS_W'(tag_len_r);
	assign last_pos = POS_W'(tag_len_r) + POS_W'(val_len_r) + POS_W'(1);
	assign val_pos = pos - eq_pos - POS_W'(1);

	always_comb begin
		if (pos < eq_pos)
			byte_o = 8'(tag_r >> {pos, 3'b000});
		else if (pos == eq_pos)
			byte_o = EQ;
		else if (pos == last_pos)
			byte_o = SOH;
		else
			byte_o = 8'(val_r >> {val_pos, 3'b000});
	end

	assign byte_valid_o = busy;
	assign done_o = busy && (pos == last_pos);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			pos <= '0;
		end else if (load_i) begin
			busy <= 1'b1;
			pos <= '0;
		end else if (done_o) begin
			busy <= 1'b0;
		end else if (busy) begin
			pos <= pos + POS_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			tag_r <= tag_i;
			tag_len_r <= tag_len_i;
			val_r <= val_i;
			val_len_r <= val_len_i;
		end
	end

	// value must fit the word and never be empty
	assert property (@(posedge clk) disable iff (rst)
		load_i |-> val_len_i != '0 && val_len_i <= LEN_W'(VALUE_BYTES));

	// sequencer waits for the field to drain
	assert property (@(posedge clk) disable iff (rst)
		load_i |-> !busy);

endmodule

//--- logic/fix_msg_builder.sv
`timescale 1ns/1ps

module fix_msg_builder #(
	parameter int VALUE_BYTES = 16,
	localparam int VW = VALUE_BYTES * 8,
	localparam int LEN_W = $clog2(VALUE_BYTES + 1)
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start_i,
	input  fix_pkg::msg_type_e msg_type_i,
	input  logic [VW-1:0]      seq_num_i,
	input  logic [LEN_W-1:0]   seq_num_len_i,
	input  logic [VW-1:0]      sender_i,
	input  logic [LEN_W-1:0]   sender_len_i,
	input  logic [VW-1:0]      target_i,
	input  logic [LEN_W-1:0]   target_len_i,
	input  logic [VW-1:0]      send_time_i,
	input  logic [LEN_W-1:0]   send_time_len_i,
	input  logic [VW-1:0]      hb_int_i,
	input  logic [LEN_W-1:0]   hb_int_len_i,
	output logic [7:0]         byte_o,
	output logic               byte_valid_o,
	output logic               busy_o,
	output logic               msg_done_o
);
	import fix_pkg::*;

	logic len_start, len_valid;
	logic [23:0] len_digits;
	logic [1:0] len_count;
	logic field_load, field_done, trailer_start;
	logic [TAG_BYTES*8-1:0] field_tag;
	logic [$clog2(TAG_BYTES+1)-1:0] field_tag_len;
	logic [VW-1:0] field_val;
	logic [LEN_W-1:0] field_val_len;
	logic [7:0] ser_byte;
	logic ser_valid;

	fix_field_sequencer #(.VALUE_BYTES(VALUE_BYTES)) i_sequencer (
		.clk(clk), .rst(rst), .start_i(start_i), .msg_type_i(msg_type_i),
		.seq_num_i(seq_num_i), .seq_num_len_i(seq_num_len_i),
		.sender_i(sender_i), .sender_len_i(sender_len_i),
		.target_i(target_i), .target_len_i(target_len_i),
		.send_time_i(send_time_i), .send_time_len_i(send_time_len_i),
		.hb_int_i(hb_int_i), .hb_int_len_i(hb_int_len_i),
		.len_valid_i(len_valid), .len_digits_i(len_digits), .len_count_i(len_count),
		.field_done_i(field_done), .trailer_done_i(msg_done_o),
		.len_start_o(len_start), .field_load_o(field_load),
		.field_tag_o(field_tag), .field_tag_len_o(field_tag_len),
		.field_val_o(field_val), .field_val_len_o(field_val_len),
		.trailer_start_o(trailer_start), .busy_o(busy_o)
	);

	fix_body_length #(.VALUE_BYTES(VALUE_BYTES)) i_body_length (
		.clk(clk), .rst(rst), .start_i(len_start), .msg_type_i(msg_type_i),
		.seq_num_len_i(seq_num_len_i), .sender_len_i(sender_len_i),
		.target_len_i(target_len_i), .send_time_len_i(send_time_len_i),
		.hb_int_len_i(hb_int_len_i),
		.len_valid_o(len_valid), .len_digits_o(len_digits), .len_count_o(len_count)
	);

	fix_field_serializer #(.VALUE_BYTES(VALUE_BYTES)) i_serializer (
		.clk(clk), .rst(rst), .load_i(field_load),
		.tag_i(field_tag), .tag_len_i(field_tag_len),
		.val_i(field_val), .val_len_i(field_val_len),
		.byte_o(ser_byte), .byte_valid_o(ser_valid), .done_o(field_done)
	);

	fix_checksum_trailer i_trailer (
		.clk(clk), .rst(rst), .byte_i(ser_byte), .byte_valid_i(ser_valid),
		.trailer_start_i(trailer_start),
		.byte_o(byte_o), .byte_valid_o(byte_valid_o), .msg_done_o(msg_done_o)
	);

endmodule

//--- logic/fix_pkg.sv
package fix_pkg;

	typedef enum logic [2:0] {
		MSG_LOGON     = 3'b001,
		MSG_HEARTBEAT = 3'b010,
		MSG_LOGOUT    = 3'b100
	} msg_type_e;

	localparam logic [7:0] SOH = 8'h01;
	localparam logic [7:0] EQ  = 8'h3d;

	localparam int TAG_BYTES = 3;

	// tag strings, first character in the low byte
	localparam logic [TAG_BYTES*8-1:0] TAG_BEGIN_STRING = 24'h000038;
	localparam logic [TAG_BYTES*8-1:0] TAG_BODY_LENGTH  = 24'h000039;
	localparam logic [TAG_BYTES*8-1:0] TAG_SEQ_NUM      = 24'h003433;
	localparam logic [TAG_BYTES*8-1:0] TAG_MSG_TYPE     = 24'h003533;
	localparam logic [TAG_BYTES*8-1:0] TAG_SENDER       = 24'h003934;
	localparam logic [TAG_BYTES*8-1:0] TAG_SEND_TIME    = 24'h003235;
	localparam logic [TAG_BYTES*8-1:0] TAG_TARGET       = 24'h003635;
	localparam logic [TAG_BYTES*8-1:0] TAG_ENCRYPT      = 24'h003839;
	localparam logic [TAG_BYTES*8-1:0] TAG_HB_INT       = 24'h383031;
	localparam logic [TAG_BYTES*8-1:0] TAG_CHECKSUM     = 24'h003031;

	localparam logic [1:0] TAG_BEGIN_STRING_LEN = 2'd1;
	localparam logic [1:0] TAG_BODY_LENGTH_LEN  = 2'd1;
	localparam logic [1:0] TAG_SEQ_NUM_LEN      = 2'd2;
	localparam logic [1:0] TAG_MSG_TYPE_LEN     = 2'd2;
	localparam logic [1:0] TAG_SENDER_LEN       = 2'd2;
	localparam logic [1:0] TAG_SEND_TIME_LEN    = 2'd2;
	localparam logic [1:0] TAG_TARGET_LEN       = 2'd2;
	localparam logic [1:0] TAG_ENCRYPT_LEN      = 2'd2;
	localparam logic [1:0] TAG_HB_INT_LEN       = 2'd3;
	localparam logic [1:0] TAG_CHECKSUM_LEN     = 2'd2;

	// "FIX.4.4"
	localparam logic [55:0] BEGIN_STRING = 56'h342e342e584946;
	localparam int BEGIN_STRING_LEN = 7;
	localparam logic [7:0] ENCRYPT_NONE = 8'h30;
	localparam int ENCRYPT_NONE_LEN = 1;

	function automatic logic [7:0] msg_type_char(msg_type_e t);
		case (t)
			MSG_LOGON:     return 8'h41;
			MSG_HEARTBEAT: return 8'h30;
			MSG_LOGOUT:    return 8'h35;
			default:       return 8'h3f;
		endcase
	endfunction

endpackage

//--- tb.f
+incdir+bench
logic/fix_pkg.sv
logic/fix_field_sequencer.sv
logic/fix_body_length.sv
logic/fix_field_serializer.sv
logic/fix_checksum_trailer.sv
logic/fix_msg_builder.sv
bench/fix_msg_builder_tb.sv
